// File: source/draw_defines.svh
/*
 * Shape drawer parameters
 * Coordinate width of one grid axis and the depth of the pixel FIFO
 */
`ifndef DRAW_DEFINES_SVH
`define DRAW_DEFINES_SVH

// Bits per axis coordinate
// A vertex is an x and a y coordinate and a shape carries three vertices
`define COORD_W 8

// Number of pixel FIFO entries kept a power of two so the pointers wrap
`define PIX_FIFO_DEPTH 8

`endif

// File: source/draw_pkg.sv
/*
 * Shape drawer types
 * Coordinate type shared by all blocks and the sequencer state encoding
 */
`include "draw_defines.svh"

package draw_pkg;

	typedef logic [`COORD_W-1:0] coord_t;

	typedef enum logic [3:0] {
		IDLE,
		DRAW2, WAIT2,
		DRAW3_1, WAIT3_1,
		DRAW3_2, WAIT3_2,
		DRAW3_3,
		DONE, DONE_WAIT
	} seq_state_t;

endpackage

// File: source/shape_sequencer.sv
/*
 * Shape sequencer
 * Breaks a line or a triangle outline into line segments and hands them
 * to the rasterizer one at a time, waiting for draw_done after each
 */
`timescale 1ns/100ps
`include "draw_defines.svh"

module shape_sequencer
	import draw_pkg::*;
(
	input  logic                  clk,
	input  logic                  n_rst,
	input  logic                  shape_start,
	input  logic                  triangle,
	input  logic [6*`COORD_W-1:0] coordinates,
	input  logic                  draw_done,
	output coord_t                x0,
	output coord_t                y0,
	output coord_t                x1,
	output coord_t                y1,
	output logic                  draw_en,
	output logic                  shape_done
);

	seq_state_t state, next_state;
	coord_t v0_x, v0_y, v1_x, v1_y, v2_x, v2_y;

	// Each vertex is x in the low byte and y in the high byte
	assign v0_x = coordinates[0*`COORD_W +: `COORD_W];
	assign v0_y = coordinates[1*`COORD_W +: `COORD_W];
	assign v1_x = coordinates[2*`COORD_W +: `COORD_W];
	assign v1_y = coordinates[3*`COORD_W +: `COORD_W];
	assign v2_x = coordinates[4*`COORD_W +: `COORD_W];
	assign v2_y = coordinates[5*`COORD_W +: `COORD_W];

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		draw_en    = 1'b0;
		shape_done = 1'b0;
		x0         = '0;
		y0         = '0;
		x1         = '0;
		y1         = '0;

		case (state)
			IDLE: begin
				if (shape_start)
					next_state = triangle ? DRAW3_1 : DRAW2;
			end
			DRAW2: begin
				draw_en = 1'b1;
				{x0, y0, x1, y1} = {v0_x, v0_y, v1_x, v1_y};
				if (draw_done)
					next_state = WAIT2;
			end
			WAIT2: begin
				// A line has a single segment, so its wait cycle is also the finish
				shape_done = 1'b1;
				next_state = DONE_WAIT;
			end
			DRAW3_1: begin
				draw_en = 1'b1;
				{x0, y0, x1, y1} = {v0_x, v0_y, v1_x, v1_y};
				if (draw_done)
					next_state = WAIT3_1;
			end
			WAIT3_1: next_state = DRAW3_2;
			DRAW3_2: begin
				draw_en = 1'b1;
				{x0, y0, x1, y1} = {v0_x, v0_y, v2_x, v2_y};
				if (draw_done)
					next_state = WAIT3_2;
			end
			WAIT3_2: next_state = DRAW3_3;
			DRAW3_3: begin
				draw_en = 1'b1;
				{x0, y0, x1, y1} = {v1_x, v1_y, v2_x, v2_y};
				if (draw_done)
					next_state = DONE;
			end
			DONE: begin
				shape_done = 1'b1;
				next_state = DONE_WAIT;
			end
			DONE_WAIT: next_state = IDLE;
			default: next_state = IDLE;
		endcase
	end

	// The rasterizer only finishes a segment that is still being drawn
	a_done_in_segment: assert property (@(posedge clk) disable iff (!n_rst)
		draw_done |-> draw_en);

endmodule

// File: source/line_rasterizer.sv
/*
 * Line rasterizer
 * Integer Bresenham walk between two endpoints, all octants, both ends
 * included, one pixel per cycle into the pixel FIFO
 */
`timescale 1ns/100ps
`include "draw_defines.svh"

module line_rasterizer
	import draw_pkg::*;
(
	input  logic   clk,
	input  logic   n_rst,
	input  logic   draw_en,
	input  coord_t x0,
	input  coord_t y0,
	input  coord_t x1,
	input  coord_t y1,
	input  logic   full,
	output logic   push,
	output coord_t px,
	output coord_t py,
	output logic   draw_done
);

	// Room for twice the largest error term with its sign
	localparam int ERR_W = `COORD_W + 3;

	logic draw_en_q;
	logic busy;
	logic start;
	logic last;
	logic step_x, step_y;
	logic x_neg, y_neg;
	coord_t cur_x, cur_y;
	coord_t end_x, end_y;
	coord_t adx, ady;
	logic signed [ERR_W-1:0] in_dx, in_dy;
	logic signed [ERR_W-1:0] dx, dy;
	logic signed [ERR_W-1:0] err, err_next, e2;

	// A new segment starts only on a rising draw_en seen while idle
	assign start = draw_en && !draw_en_q && !busy;

	assign adx = (x1 >= x0) ? x1 - x0 : x0 - x1;
	assign ady = (y1 >= y0) ? y1 - y0 : y0 - y1;
	assign in_dx = $signed(ERR_W'(adx));
	assign in_dy = -$signed(ERR_W'(ady)); // Kept negative as in the classic form

	assign last      = (cur_x == end_x) && (cur_y == end_y);
	assign push      = busy && !full;
	assign draw_done = push && last;
	assign px        = cur_x;
	assign py        = cur_y;

	assign e2     = err <<< 1;
	assign step_x = e2 >= dy;
	assign step_y = e2 <= dx;

	always_comb begin
		err_next = err;
		if (step_x)
			err_next = err_next + dy;
		if (step_y)
			err_next = err_next + dx;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			busy      <= 1'b0;
			draw_en_q <= 1'b0;
		end else begin
			draw_en_q <= draw_en;
			if (start)
				busy <= 1'b1;
			else if (draw_done)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			cur_x <= x0;
			cur_y <= y0;
			end_x <= x1;
			end_y <= y1;
			x_neg <= x1 < x0;
			y_neg <= y1 < y0;
			dx    <= in_dx;
			dy    <= in_dy;
			err   <= in_dx + in_dy;
		end else if (push && !last) begin
			err <= err_next;
			if (step_x)
				cur_x <= x_neg ? cur_x - 1'b1 : cur_x + 1'b1;
			if (step_y)
				cur_y <= y_neg ? cur_y - 1'b1 : cur_y + 1'b1;
		end
	end

	// The sequencer keeps draw_en up for as long as a segment is walked
	a_segment_level: assert property (@(posedge clk) disable iff (!n_rst)
		busy |-> draw_en);

endmodule

// File: source/pixel_fifo.sv
/*
 * Pixel FIFO
 * Show-ahead circular buffer of pixel coordinates between the
 * rasterizer and the pixel writer
 */
`timescale 1ns/100ps
`include "draw_defines.svh"

module pixel_fifo
	import draw_pkg::*;
(
	input  logic   clk,
	input  logic   n_rst,
	input  logic   push,
	input  coord_t wr_x,
	input  coord_t wr_y,
	input  logic   pop,
	output coord_t rd_x,
	output coord_t rd_y,
	output logic   full,
	output logic   empty
);

	localparam int DEPTH = `PIX_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	coord_t mem_x [DEPTH];
	coord_t mem_y [DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [PTR_W:0]   count;

	assign full  = count == (PTR_W+1)'(DEPTH);
	assign empty = count == '0;
	assign rd_x  = mem_x[rd_ptr]; // Head is valid whenever empty is low
	assign rd_y  = mem_y[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem_x[wr_ptr] <= wr_x;
			mem_y[wr_ptr] <= wr_y;
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!n_rst) push |-> !full);
	a_no_underflow: assert property (@(posedge clk) disable iff (!n_rst) pop |-> !empty);

endmodule

// File: source/pixel_writer.sv
/*
 * Pixel writer
 * Drains the pixel FIFO to the external pixel port whenever the port
 * is not busy, with a registered write strobe and coordinates
 */
`timescale 1ns/100ps

module pixel_writer
	import draw_pkg::*;
(
	input  logic   clk,
	input  logic   n_rst,
	input  logic   empty,
	input  coord_t rd_x,
	input  coord_t rd_y,
	input  logic   pix_busy,
	output logic   pop,
	output logic   pix_we,
	output coord_t pix_x,
	output coord_t pix_y
);

	// One pixel leaves per cycle while the port accepts it
	assign pop = !empty && !pix_busy;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			pix_we <= 1'b0;
		else
			pix_we <= pop;
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			pix_x <= rd_x;
			pix_y <= rd_y;
		end
	end

endmodule

// File: source/shape_drawer.sv
/*
 * Shape drawer top level
 * Sequencer, Bresenham rasterizer, pixel FIFO and pixel writer in a chain
 */
`timescale 1ns/100ps
`include "draw_defines.svh"

module shape_drawer
	import draw_pkg::*;
(
	input  logic                  clk,
	input  logic                  n_rst,
	input  logic                  shape_start,
	input  logic                  triangle,
	input  logic [6*`COORD_W-1:0] coordinates,
	input  logic                  pix_busy,
	output logic                  pix_we,
	output coord_t                pix_x,
	output coord_t                pix_y,
	output logic                  shape_done
);

	logic   draw_en, draw_done;
	coord_t x0, y0, x1, y1;
	logic   push, pop, full, empty;
	coord_t px, py;
	coord_t rd_x, rd_y;

	shape_sequencer u_seq (
		.clk, .n_rst, .shape_start, .triangle, .coordinates, .draw_done,
		.x0, .y0, .x1, .y1, .draw_en, .shape_done
	);

	line_rasterizer u_rast (
		.clk, .n_rst, .draw_en, .x0, .y0, .x1, .y1, .full,
		.push, .px, .py, .draw_done
	);

	pixel_fifo u_fifo (
		.clk, .n_rst, .push, .wr_x(px), .wr_y(py), .pop,
		.rd_x, .rd_y, .full, .empty
	);

	pixel_writer u_writer (
		.clk, .n_rst, .empty, .rd_x, .rd_y, .pix_busy,
		.pop, .pix_we, .pix_x, .pix_y
	);

endmodule

// File: sim/tb_clock.sv
/*
 * Testbench clock generator
 * Free running clock with a 10 ns period by default
 */
`timescale 1ns/100ps

module tb_clock #(
	parameter int HALF_PERIOD = 5
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

endmodule

// File: sim/tb_shape_drawer.sv
/*
 * Shape drawer testbench
 * Directed line and triangle tests checked against a Bresenham model,
 * with random back-pressure on the pixel port and a reset in mid-shape
 */
`timescale 1ns/100ps
`include "draw_defines.svh"

module tb_shape_drawer
	import draw_pkg::*;
();

	localparam logic [31:0] SEED = 32'h7b58_fcf8;
	localparam int DONE_TIMEOUT = 10000;
	localparam int PIX_TIMEOUT = 4000;
	localparam int SETTLE = 4*`PIX_FIFO_DEPTH + 8;

	logic clk;
	logic n_rst;
	logic shape_start;
	logic triangle;
	logic [6*`COORD_W-1:0] coordinates;
	logic pix_busy = 1'b0;
	logic pix_we;
	logic shape_done;
	coord_t pix_x, pix_y;

	logic [2*`COORD_W-1:0] exp_q[$]; // Pixels as {x, y}
	logic [2*`COORD_W-1:0] got_q[$];
	logic [31:0] rng;
	logic [31:0] busy_rng = SEED;
	logic busy_random = 1'b0;
	logic busy_now;
	logic busy_seen = 1'b0;

	tb_clock u_clk (.clk);

	shape_drawer uut (
		.clk, .n_rst, .shape_start, .triangle, .coordinates, .pix_busy,
		.pix_we, .pix_x, .pix_y, .shape_done
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] next_random();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic logic [2*`COORD_W-1:0] pack_pixel(input int x, input int y);
		return {coord_t'(x), coord_t'(y)};
	endfunction

	function automatic logic [6*`COORD_W-1:0] vertices(input int ax, input int ay,
			input int bx, input int by, input int cx, input int cy);
		return {coord_t'(cy), coord_t'(cx), coord_t'(by), coord_t'(bx),
			coord_t'(ay), coord_t'(ax)};
	endfunction

	// Classic integer Bresenham with both endpoints included
	task automatic add_segment(input int xa, input int ya, input int xb, input int yb);
		int dx, dy, sx, sy, err, e2, x, y;
		dx = (xb > xa) ? xb - xa : xa - xb;
		dy = (yb > ya) ? ya - yb : yb - ya;
		sx = (xb >= xa) ? 1 : -1;
		sy = (yb >= ya) ? 1 : -1;
		err = dx + dy;
		x = xa;
		y = ya;
		exp_q.push_back(pack_pixel(x, y));
		while (x != xb || y != yb) begin
			e2 = 2 * err;
			if (e2 >= dy) begin
				err = err + dy;
				x = x + sx;
			end
			if (e2 <= dx) begin
				err = err + dx;
				y = y + sy;
			end
			exp_q.push_back(pack_pixel(x, y));
		end
	endtask

	task automatic start_shape(input logic is_tri, input logic [6*`COORD_W-1:0] coords);
		int vx[3], vy[3];
		for (int i = 0; i < 3; i++) begin
			vx[i] = int'(coords[2*i*`COORD_W +: `COORD_W]);
			vy[i] = int'(coords[(2*i+1)*`COORD_W +: `COORD_W]);
		end
		exp_q.delete();
		got_q.delete();
		add_segment(vx[0], vy[0], vx[1], vy[1]);
		if (is_tri) begin
			add_segment(vx[0], vy[0], vx[2], vy[2]);
			add_segment(vx[1], vy[1], vx[2], vy[2]);
		end
		triangle = is_tri;
		coordinates = coords;
		shape_start = 1'b1;
		tick();
		shape_start = 1'b0;
	endtask

	task automatic finish_shape(input string name);
		int n;
		n = 0;
		while (!shape_done && n < DONE_TIMEOUT) begin
			tick();
			n++;
		end
		assert (shape_done) else fail_run({name, ": timed out waiting for shape_done"});
		n = 0;
		while (got_q.size() < exp_q.size() && n < PIX_TIMEOUT) begin
			tick();
			n++;
		end
		assert (got_q.size() >= exp_q.size())
		else fail_run({name, ": timed out waiting for pixels on the port"});
		repeat (SETTLE) tick(); // Any extra pixel would show up here
		assert (got_q.size() == exp_q.size())
		else fail_run($sformatf("ERR %s: pixel count expected %0d actual %0d",
			name, exp_q.size(), got_q.size()));
		for (int i = 0; i < exp_q.size(); i++) begin
			assert (got_q[i] == exp_q[i])
			else fail_run($sformatf("ERR %s: pixel %0d expected (%0d,%0d) actual (%0d,%0d)",
				name, i, exp_q[i][15:8], exp_q[i][7:0], got_q[i][15:8], got_q[i][7:0]));
		end
	endtask

	task automatic draw_shape(input string name, input logic is_tri,
			input logic [6*`COORD_W-1:0] coords);
		start_shape(is_tri, coords);
		finish_shape(name);
	endtask

	task automatic basic_lines();
		draw_shape("horizontal", 1'b0, vertices(10, 20, 40, 20, 0, 0));
		draw_shape("horizontal_back", 1'b0, vertices(200, 3, 180, 3, 0, 0));
		draw_shape("vertical", 1'b0, vertices(5, 5, 5, 30, 0, 0));
		draw_shape("diagonal", 1'b0, vertices(0, 0, 20, 20, 0, 0));
		draw_shape("single_point", 1'b0, vertices(7, 9, 7, 9, 0, 0));
	endtask

	task automatic all_octants();
		logic [31:0] r1, r2;
		for (int i = 0; i < 40; i++) begin
			r1 = next_random();
			r2 = next_random();
			draw_shape($sformatf("octant_line_%0d", i), 1'b0, {r1[15:0], r2});
		end
	endtask

	task automatic triangles();
		logic [31:0] r1, r2;
		draw_shape("triangle_fixed", 1'b1, vertices(10, 10, 50, 20, 30, 60));
		for (int i = 0; i < 5; i++) begin
			r1 = next_random();
			r2 = next_random();
			draw_shape($sformatf("triangle_%0d", i), 1'b1, {r1[15:0], r2});
		end
	endtask

	task automatic back_pressure();
		logic [31:0] r1, r2;
		busy_random = 1'b1;
		draw_shape("busy_long", 1'b0, vertices(0, 0, 255, 100, 0, 0));
		draw_shape("busy_steep", 1'b0, vertices(250, 240, 3, 17, 0, 0));
		r1 = next_random();
		r2 = next_random();
		draw_shape("busy_triangle", 1'b1, {r1[15:0], r2});
		busy_random = 1'b0;
	endtask

	task automatic start_and_reset();
		start_shape(1'b0, vertices(0, 0, 200, 50, 0, 0));
		repeat (6) tick();
		triangle = 1'b1; // The sequencer is busy and must ignore this start
		shape_start = 1'b1;
		tick();
		shape_start = 1'b0;
		triangle = 1'b0;
		finish_shape("ignored_start");

		start_shape(1'b1, vertices(10, 200, 220, 30, 90, 120));
		repeat (20) tick();
		n_rst = 1'b0;
		got_q.delete();
		repeat (3) begin
			tick();
			assert (!pix_we && !shape_done) else fail_run("pix_we or shape_done high in reset");
		end
		n_rst = 1'b1;
		repeat (SETTLE) begin
			tick();
			assert (!shape_done) else fail_run("shape_done pulsed after a mid-shape reset");
		end
		assert (got_q.size() == 0)
		else fail_run($sformatf("ERR mid_reset: pixel count expected 0 actual %0d",
			got_q.size()));
		draw_shape("after_reset", 1'b0, vertices(3, 250, 60, 200, 0, 0));
	endtask

	// Records every port write and checks the busy rule
	always @(posedge clk) begin
		if (n_rst) begin
			if (pix_we)
				got_q.push_back({pix_x, pix_y});
			assert (!(pix_we && busy_seen))
			else fail_run("pixel written in the cycle after the port was busy");
		end
		busy_seen = pix_busy;
	end

	always @(posedge clk) begin
		busy_now = busy_random;
		#1;
		if (busy_now) begin
			busy_rng = xorshift(busy_rng);
			pix_busy = busy_rng[2:0] < 3'd4;
		end else begin
			pix_busy = 1'b0;
		end
	end

	initial begin
		n_rst = 1'b0;
		shape_start = 1'b0;
		triangle = 1'b0;
		coordinates = '0;
		rng = SEED;
		repeat (10) tick();
		n_rst = 1'b1;
		tick();
		basic_lines();
		all_octants();
		triangles();
		back_pressure();
		start_and_reset();
		$display("test passed");
		$finish;
	end

endmodule

// File: shape_drawer.f
+incdir+source
source/draw_pkg.sv
source/shape_sequencer.sv
source/line_rasterizer.sv
source/pixel_fifo.sv
source/pixel_writer.sv
source/shape_drawer.sv
sim/tb_clock.sv
sim/tb_shape_drawer.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the shape drawer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_shape_drawer \
	-f shape_drawer.f \
	-o tb_shape_drawer

./obj_dir/tb_shape_drawer
